/* Bender.yml */
package:
  name: wbserial

sources:
  - include_dirs:
      - logic
    files:
      - logic/wbserial_pkg.sv
      - logic/wb_reg_bank.sv
      - logic/wb_timer_periph.sv
      - logic/wb_periph_mux.sv
      - logic/wb_ctrl_sync.sv
      - logic/wbserial_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_wbserial.sv

/* logic/wb_ctrl_sync.sv */
`include "wbserial_defines.svh"

// Frame format, one tx byte for every rx byte
//
//   read   rx: cmd   fill* fill  fill
//          tx: 00    00*   01    data
//
//   write  rx: cmd   data  fill* fill
//          tx: 00    00    00*   01
module wb_ctrl_sync (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`WBS_DATA_W-1:0]  rx_data_i,
  input  logic                    rx_valid_i,
  output logic [`WBS_DATA_W-1:0]  tx_data_o,
  output logic                    tx_valid_o,
  output wbserial_pkg::wb_req_t   bus_req_o,
  input  wbserial_pkg::wb_rsp_t   bus_rsp_i
);

  wbserial_pkg::ctrl_state_e state_d, state_q;

  logic                   we_d, we_q;
  logic [`WBS_ADDR_W-1:0] adr_d, adr_q;
  logic                   ack_d, ack_q;
  logic                   ack_seen;
  logic                   stb;
  logic [`WBS_DATA_W-1:0] rdata_q;
  logic [`WBS_DATA_W-1:0] tx_data;

  // Ack arriving this cycle counts as seen right away
  assign ack_seen = ack_q | bus_rsp_i.ack;

  // Every received byte gets an answer in the same cycle
  assign tx_valid_o = rx_valid_i;
  assign tx_data_o  = tx_data;

  // Address and write flag come from the next-state side so that they
  // line up with the strobe issued in the command cycle
  always_comb begin
    bus_req_o     = '0;
    bus_req_o.we  = we_d;
    bus_req_o.adr = adr_d;
    bus_req_o.dat = rx_data_i;
    bus_req_o.stb = stb;
  end

  always_comb begin
    state_d = state_q;
    we_d    = we_q;
    adr_d   = adr_q;
    ack_d   = ack_seen;
    stb     = 1'b0;
    tx_data = '0;

    case (state_q)
      wbserial_pkg::Idle: begin
        if (rx_valid_i) begin
          we_d  = rx_data_i[`WBS_WRITE_BIT];
          adr_d = rx_data_i[`WBS_ADDR_W-1:0];
          // New frame starts with no ack pending
          ack_d = 1'b0;
          if (rx_data_i[`WBS_WRITE_BIT]) begin
            state_d = wbserial_pkg::WriteGetData;
          end else begin
            stb     = 1'b1;
            state_d = wbserial_pkg::ReadWaitAck;
          end
        end
      end

      wbserial_pkg::WriteGetData: begin
        if (rx_valid_i) begin
          stb     = 1'b1;
          state_d = wbserial_pkg::WriteWaitAck;
        end
      end

      wbserial_pkg::ReadWaitAck: begin
        if (rx_valid_i && ack_seen) begin
          tx_data = 8'h01;
          state_d = wbserial_pkg::ReadPutData;
        end
      end

      wbserial_pkg::ReadPutData: begin
        if (rx_valid_i) begin
          tx_data = rdata_q;
          state_d = wbserial_pkg::Idle;
        end
      end

      wbserial_pkg::WriteWaitAck: begin
        if (rx_valid_i && ack_seen) begin
          tx_data = 8'h01;
          state_d = wbserial_pkg::Idle;
        end
      end

      // Stuck here until reset
      wbserial_pkg::Invalid: begin
        state_d = wbserial_pkg::Invalid;
      end

      default: begin
        state_d = wbserial_pkg::Invalid;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= wbserial_pkg::Idle;
      we_q    <= 1'b0;
      adr_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      we_q    <= we_d;
      adr_q   <= adr_d;
      ack_q   <= ack_d;
    end
  end

  // Read data is kept with the ack until the data byte goes out
  always_ff @(posedge clk_i) begin
    if (bus_rsp_i.ack) begin
      rdata_q <= bus_rsp_i.dat;
    end
  end

endmodule

/* logic/wb_periph_mux.sv */
`include "wbserial_defines.svh"

module wb_periph_mux (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  wbserial_pkg::wb_req_t bus_req_i,
  output wbserial_pkg::wb_rsp_t bus_rsp_o,
  output wbserial_pkg::wb_req_t reg_req_o,
  input  wbserial_pkg::wb_rsp_t reg_rsp_i,
  output wbserial_pkg::wb_req_t tmr_req_o,
  input  wbserial_pkg::wb_rsp_t tmr_rsp_i
);

  logic sel_tmr;
  logic sel_tmr_q;

  assign sel_tmr = bus_req_i.adr[`WBS_PERIPH_SEL_BIT];

  // Both peripherals see the local address, only one gets the strobe
  always_comb begin
    reg_req_o     = bus_req_i;
    tmr_req_o     = bus_req_i;
    reg_req_o.adr = {1'b0, bus_req_i.adr[2:0]};
    tmr_req_o.adr = {1'b0, bus_req_i.adr[2:0]};
    reg_req_o.stb = bus_req_i.stb & ~sel_tmr;
    tmr_req_o.stb = bus_req_i.stb & sel_tmr;
  end

  // The response shows up a cycle after the strobe, by then the
  // master may already present a different address
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sel_tmr_q <= 1'b0;
    end else if (bus_req_i.stb) begin
      sel_tmr_q <= sel_tmr;
    end
  end

  always_comb begin
    if (sel_tmr_q) begin
      bus_rsp_o = tmr_rsp_i;
    end else begin
      bus_rsp_o = reg_rsp_i;
    end
  end

endmodule

/* logic/wb_reg_bank.sv */
`include "wbserial_defines.svh"

module wb_reg_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  wbserial_pkg::wb_req_t bus_req_i,
  output wbserial_pkg::wb_rsp_t bus_rsp_o
);

  localparam int unsigned IDX_W = $clog2(`WBS_NUM_REGS);

  logic [`WBS_DATA_W-1:0] regs_q [`WBS_NUM_REGS];
  logic [IDX_W-1:0]       idx;
  logic                   ack_q;
  logic [`WBS_DATA_W-1:0] rdat_q;

  assign idx = bus_req_i.adr[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WBS_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req_i.stb;
      if (bus_req_i.stb && bus_req_i.we) begin
        regs_q[idx] <= bus_req_i.dat;
      end
    end
  end

  // A write returns the old contents, nobody looks at it
  always_ff @(posedge clk_i) begin
    if (bus_req_i.stb) begin
      rdat_q <= regs_q[idx];
    end
  end

  always_comb begin
    bus_rsp_o     = '0;
    bus_rsp_o.dat = rdat_q;
    bus_rsp_o.ack = ack_q;
  end

endmodule

/* logic/wb_timer_periph.sv */
`include "wbserial_defines.svh"

module wb_timer_periph (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  wbserial_pkg::wb_req_t bus_req_i,
  output wbserial_pkg::wb_rsp_t bus_rsp_o
);

  localparam int unsigned CNT_W = 2 * `WBS_DATA_W;

  wbserial_pkg::timer_reg_e reg_sel;

  logic                   wr, rd;
  logic [CNT_W-1:0]       count_q;
  logic                   en_q;
  logic [`WBS_DATA_W-1:0] cmp_q;
  logic                   match_q;
  logic [`WBS_DATA_W-1:0] hi_snap_q;
  logic [`WBS_DATA_W-1:0] rdata;
  logic                   ack_q;
  logic [`WBS_DATA_W-1:0] rdat_q;

  assign reg_sel = wbserial_pkg::timer_reg_e'(bus_req_i.adr[2:0]);
  assign wr      = bus_req_i.stb & bus_req_i.we;
  assign rd      = bus_req_i.stb & ~bus_req_i.we;

  always_comb begin
    case (reg_sel)
      wbserial_pkg::TmrCtrl:    rdata = {{(`WBS_DATA_W-1){1'b0}}, en_q};
      wbserial_pkg::TmrCountLo: rdata = count_q[`WBS_DATA_W-1:0];
      wbserial_pkg::TmrCountHi: rdata = hi_snap_q;
      wbserial_pkg::TmrCompare: rdata = cmp_q;
      wbserial_pkg::TmrStatus:  rdata = {{(`WBS_DATA_W-1){1'b0}}, match_q};
      default:                  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q   <= '0;
      en_q      <= 1'b0;
      cmp_q     <= '0;
      match_q   <= 1'b0;
      hi_snap_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= bus_req_i.stb;

      // Bus loads take priority over counting
      if (wr && reg_sel == wbserial_pkg::TmrCountLo) begin
        count_q[`WBS_DATA_W-1:0] <= bus_req_i.dat;
      end else if (wr && reg_sel == wbserial_pkg::TmrCountHi) begin
        count_q[CNT_W-1:`WBS_DATA_W] <= bus_req_i.dat;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end

      if (wr && reg_sel == wbserial_pkg::TmrCtrl) begin
        en_q <= bus_req_i.dat[0];
      end
      if (wr && reg_sel == wbserial_pkg::TmrCompare) begin
        cmp_q <= bus_req_i.dat;
      end

      // Match flag is sticky, only a status write clears it
      if (wr && reg_sel == wbserial_pkg::TmrStatus && bus_req_i.dat[0]) begin
        match_q <= 1'b0;
      end else if (en_q && count_q[`WBS_DATA_W-1:0] == cmp_q) begin
        match_q <= 1'b1;
      end

      // High byte frozen at the low byte read keeps the pair coherent
      if (rd && reg_sel == wbserial_pkg::TmrCountLo) begin
        hi_snap_q <= count_q[CNT_W-1:`WBS_DATA_W];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.stb) begin
      rdat_q <= rdata;
    end
  end

  always_comb begin
    bus_rsp_o     = '0;
    bus_rsp_o.dat = rdat_q;
    bus_rsp_o.ack = ack_q;
  end

endmodule

/* logic/wbserial_defines.svh */
`ifndef WBSERIAL_DEFINES_SVH
`define WBSERIAL_DEFINES_SVH

// Local bus widths
`define WBS_ADDR_W 4
`define WBS_DATA_W 8

// General purpose registers in the register bank
`define WBS_NUM_REGS 8

// Command byte layout, write flag on top and address in the low nibble
`define WBS_WRITE_BIT 7

// Address bit 3 picks the timer, otherwise the register bank answers
`define WBS_PERIPH_SEL_BIT 3

`endif

/* logic/wbserial_pkg.sv */
`include "wbserial_defines.svh"

package wbserial_pkg;

  // Request from a bus master toward a peripheral
  typedef struct packed {
    logic                   we;
    logic [`WBS_ADDR_W-1:0] adr;
    logic [`WBS_DATA_W-1:0] dat;
    logic                   stb;
  } wb_req_t;

  // Response back from a peripheral
  typedef struct packed {
    logic [`WBS_DATA_W-1:0] dat;
    logic                   ack;
  } wb_rsp_t;

  // Frame decoder states
  typedef enum logic [2:0] {
    Idle,
    WriteGetData,
    ReadWaitAck,
    ReadPutData,
    WriteWaitAck,
    Invalid
  } ctrl_state_e;

  // Timer register map, codes 5..7 reserved
  typedef enum logic [2:0] {
    TmrCtrl    = 3'd0,
    TmrCountLo = 3'd1,
    TmrCountHi = 3'd2,
    TmrCompare = 3'd3,
    TmrStatus  = 3'd4
  } timer_reg_e;

endpackage

/* logic/wbserial_top.sv */
`include "wbserial_defines.svh"

module wbserial_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`WBS_DATA_W-1:0] rx_data_i,
  input  logic                   rx_valid_i,
  output logic [`WBS_DATA_W-1:0] tx_data_o,
  output logic                   tx_valid_o
);

  wbserial_pkg::wb_req_t ctrl_req;
  wbserial_pkg::wb_rsp_t ctrl_rsp;
  wbserial_pkg::wb_req_t reg_req;
  wbserial_pkg::wb_rsp_t reg_rsp;
  wbserial_pkg::wb_req_t tmr_req;
  wbserial_pkg::wb_rsp_t tmr_rsp;

  wb_ctrl_sync u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o),
    .bus_req_o  (ctrl_req),
    .bus_rsp_i  (ctrl_rsp)
  );

  wb_periph_mux u_mux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (ctrl_req),
    .bus_rsp_o (ctrl_rsp),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp),
    .tmr_req_o (tmr_req),
    .tmr_rsp_i (tmr_rsp)
  );

  // Addresses 0..7
  wb_reg_bank u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (reg_req),
    .bus_rsp_o (reg_rsp)
  );

  // Addresses 8..15
  wb_timer_periph u_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (tmr_req),
    .bus_rsp_o (tmr_rsp)
  );

endmodule

/* testbench/tb_wbserial.sv */
`include "wbserial_defines.svh"

module tb_wbserial;

  localparam int CLK_HALF        = 20;
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_FRAMES      = 130;
  localparam int MAX_FRAME_BYTES = 6;
  localparam int CYCLES_PER_BYTE = 5;
  localparam int TIMEOUT_CYCLES  = NUM_FRAMES * MAX_FRAME_BYTES * CYCLES_PER_BYTE
                                   + RESET_CYCLES + 200;
  localparam int STATUS_POLLS    = 40;

  // Timer sits at 8..15
  localparam logic [3:0] TMR_CTRL   = {1'b1, wbserial_pkg::TmrCtrl};
  localparam logic [3:0] TMR_CNT_LO = {1'b1, wbserial_pkg::TmrCountLo};
  localparam logic [3:0] TMR_CNT_HI = {1'b1, wbserial_pkg::TmrCountHi};
  localparam logic [3:0] TMR_CMP    = {1'b1, wbserial_pkg::TmrCompare};
  localparam logic [3:0] TMR_STATUS = {1'b1, wbserial_pkg::TmrStatus};

  logic       clk_i;
  logic       rst_ni;
  logic [7:0] rx_data_i;
  logic       rx_valid_i;
  logic [7:0] tx_data_o;
  logic       tx_valid_o;

  logic [31:0] rng_state;
  logic [7:0]  model [16];
  int          value_errs;
  int          other_errs;
  int          cycle_count;

  wbserial_top u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // Stream rules hold on every clock including reset
  valid_follows: assert property (@(posedge clk_i) tx_valid_o == rx_valid_i)
    else begin
      other_errs++;
      $display("tx_valid_o did not follow rx_valid_i at time %0t", $time);
    end

  quiet_when_idle: assert property (@(posedge clk_i) !rx_valid_i |-> !tx_valid_o)
    else begin
      other_errs++;
      $display("tx_valid_o was high with no byte arriving at time %0t", $time);
    end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the frames", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp)
    else begin
      value_errs++;
      $display("FAILED %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  // Byte follows up to three idle cycles and its answer is sampled at the rising edge
  task automatic send_byte(input logic [7:0] b, output logic [7:0] rsp);
    logic [31:0] r;
    r = next_rand();
    @(negedge clk_i);
    if (r[1:0] != 2'd0) begin
      rx_valid_i = 1'b0;
      repeat (r[1:0]) @(negedge clk_i);
    end
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    @(posedge clk_i);
    rsp = tx_data_o;
  endtask

  task automatic end_frame();
    @(negedge clk_i);
    rx_valid_i = 1'b0;
  endtask

  task automatic run_frame(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    logic [7:0]  rsp_q [$];
    logic [7:0]  rsp;
    logic [7:0]  cmd;
    logic [31:0] fill;
    int          marker;
    int          limit;
    rdat   = '0;
    marker = -1;
    limit  = we ? MAX_FRAME_BYTES : MAX_FRAME_BYTES - 1;
    cmd    = {4'h0, adr};
    cmd[`WBS_WRITE_BIT] = we;
    send_byte(cmd, rsp);
    rsp_q.push_back(rsp);
    if (we) begin
      send_byte(wdat, rsp);
      rsp_q.push_back(rsp);
    end
    while (marker < 0 && rsp_q.size() < limit) begin
      fill = next_rand();
      send_byte(fill[7:0], rsp);
      rsp_q.push_back(rsp);
      if (rsp == 8'h01) begin
        marker = rsp_q.size() - 1;
      end
    end
    if (marker < 0) begin
      other_errs++;
      $display("No ack marker within %0d bytes of the frame to address %h", limit, adr);
    end else if (!we) begin
      // One more filler fetches the read data
      fill = next_rand();
      send_byte(fill[7:0], rsp);
      rsp_q.push_back(rsp);
      rdat = rsp;
    end
    for (int i = 0; i < marker; i++) begin
      check_value("tx_data_o", 8'h00, rsp_q[i]);
    end
    end_frame();
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    run_frame(1'b1, adr, dat, unused);
    if (adr < `WBS_NUM_REGS) begin
      model[adr] = dat;
    end else if (adr == TMR_CTRL) begin
      model[adr] = {7'd0, dat[0]};
    end else if (adr == TMR_CMP) begin
      model[adr] = dat;
    end
  endtask

  task automatic read_value(input logic [3:0] adr, output logic [7:0] rdat);
    run_frame(1'b0, adr, 8'h00, rdat);
  endtask

  task automatic read_check(input logic [3:0] adr);
    logic [7:0] rdat;
    read_value(adr, rdat);
    check_value($sformatf("tx_data_o (address %h)", adr), model[adr], rdat);
  endtask

  initial begin
    logic [7:0]  rdat;
    logic [7:0]  lo_a;
    logic [7:0]  lo_b;
    logic [31:0] r;
    int          polls;
    rst_ni      = 1'b0;
    rx_valid_i  = 1'b0;
    rx_data_i   = '0;
    rng_state   = 32'hd47f;
    value_errs  = 0;
    other_errs  = 0;
    cycle_count = 0;
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) @(negedge clk_i);

    // Everything reads zero out of reset
    for (int a = 0; a < 16; a++) begin
      read_check(4'(a));
    end

    for (int a = 0; a < `WBS_NUM_REGS; a++) begin
      r = next_rand();
      write_reg(4'(a), r[7:0]);
    end
    for (int a = 0; a < `WBS_NUM_REGS; a++) begin
      read_check(4'(a));
    end
    write_reg(4'd5, ~model[5]);
    for (int a = 0; a < `WBS_NUM_REGS; a++) begin
      read_check(4'(a));
    end

    // Count loads and the high byte snapshot with the timer stopped
    write_reg(TMR_CNT_LO, 8'h5a);
    write_reg(TMR_CNT_HI, 8'hc3);
    read_value(TMR_CNT_LO, rdat);
    check_value("tx_data_o (count low byte)", 8'h5a, rdat);
    read_value(TMR_CNT_HI, rdat);
    check_value("tx_data_o (count high byte)", 8'hc3, rdat);
    write_reg(TMR_CNT_HI, 8'h7e);
    read_value(TMR_CNT_HI, rdat);
    check_value("tx_data_o (count high snapshot)", 8'hc3, rdat);
    read_value(TMR_CNT_LO, rdat);
    check_value("tx_data_o (count low byte)", 8'h5a, rdat);
    read_value(TMR_CNT_HI, rdat);
    check_value("tx_data_o (count high snapshot)", 8'h7e, rdat);
    for (int a = 13; a < 16; a++) begin
      r = next_rand();
      write_reg(4'(a), r[7:0] | 8'h01);
      read_check(4'(a));
    end

    // Each peripheral keeps out of the other's state
    write_reg(TMR_CMP, ~model[3]);
    for (int a = 0; a < `WBS_NUM_REGS; a++) begin
      read_check(4'(a));
    end
    write_reg(4'd3, ~model[TMR_CMP]);
    read_check(TMR_CMP);

    // Running timer
    write_reg(TMR_CNT_LO, 8'h00);
    write_reg(TMR_CNT_HI, 8'h00);
    write_reg(TMR_CMP, 8'h40);
    write_reg(TMR_CTRL, 8'h01);
    read_check(TMR_CTRL);
    read_value(TMR_CNT_LO, lo_a);
    read_value(TMR_CNT_LO, lo_b);
    assert (lo_a != lo_b)
    else begin
      other_errs++;
      $display("Timer count did not advance between two reads while enabled");
    end
    polls = 0;
    rdat  = '0;
    while (!rdat[0] && polls < STATUS_POLLS) begin
      read_value(TMR_STATUS, rdat);
      polls++;
    end
    assert (rdat[0])
    else begin
      other_errs++;
      $display("Match flag never set within %0d status reads", STATUS_POLLS);
    end
    write_reg(TMR_STATUS, 8'h01);
    read_value(TMR_STATUS, rdat);
    check_value("tx_data_o (match flag)", 8'h00, rdat);

    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* wbserial.f */
+incdir+logic
logic/wbserial_pkg.sv
logic/wb_reg_bank.sv
logic/wb_timer_periph.sv
logic/wb_periph_mux.sv
logic/wb_ctrl_sync.sv
logic/wbserial_top.sv
testbench/tb_wbserial.sv
